/* design/commitUnit.sv */
`include "coreCfg.svh"

module commitUnit import renamePkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              allocValid,
    input  logic [`SQN_W-1:0] allocSqN,
    input  logic              wbValid,
    input  wbRes_t            wbRes,
    output logic              comValid,
    output comInfo_t          comInfo,
    output logic [4:0]        comRegNm,
    output logic [`XLEN-1:0]  comValue,
    output logic [`XLEN-1:0]  comPc,
    output logic [`SQN_W-1:0] headSqN,
    output logic              flush,
    output logic [`SQN_W-1:0] flushSqN,
    output logic [`XLEN-1:0]  redirectPc
);

    localparam int RIDX = $clog2(`ROB_DEPTH);

    typedef struct packed {
        logic [`XLEN-1:0]  value;
        logic [4:0]        rd;
        logic [`TAG_W-1:0] tag;
        logic [`XLEN-1:0]  pc;
        logic              taken;
        logic [`XLEN-1:0]  target;
    } robEntry_t;

    robEntry_t             rob [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] robBusy;
    logic [`ROB_DEPTH-1:0] robDone;
    logic [RIDX-1:0]       headIdx;
    logic [RIDX-1:0]       wbIdx;
    robEntry_t             head;

    assign headIdx = headSqN[RIDX-1:0];
    assign wbIdx = wbRes.sqN[RIDX-1:0];
    assign head = rob[headIdx];

    // Head retires once its result is in
    assign comValid = robBusy[headIdx] && robDone[headIdx];
    assign comInfo = '{regNm: head.rd, tag: head.tag};
    assign comRegNm = head.rd;
    assign comValue = head.value;
    assign comPc = head.pc;
    assign flush = comValid && head.taken;
    assign flushSqN = headSqN;
    assign redirectPc = head.target;

    always_ff @(posedge clk) begin
        if (rst) begin
            robBusy <= '0;
            robDone <= '0;
            headSqN <= '0;
        end else begin
            if (allocValid) begin
                robBusy[allocSqN[RIDX-1:0]] <= 1'b1;
                robDone[allocSqN[RIDX-1:0]] <= 1'b0;
            end
            if (wbValid) begin
                robDone[wbIdx] <= 1'b1;
                rob[wbIdx] <= '{value: wbRes.value, rd: wbRes.rd, tag: wbRes.tagDst,
                                pc: wbRes.pc, taken: wbRes.taken, target: wbRes.target};
            end
            if (comValid) begin
                robBusy[headIdx] <= 1'b0;
                robDone[headIdx] <= 1'b0;
                headSqN <= headSqN + 1'b1;
            end
            if (flush) begin
                robBusy <= '0;
                robDone <= '0;
            end
        end
    end

    aWbBusy: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> robBusy[wbIdx] && !robDone[wbIdx])
        else $error("completion for idle entry sqN %0d", wbRes.sqN);

endmodule

/* design/coreCfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath width
`define XLEN 32

// Physical tags and their index width
`define NUM_TAGS 64
`define TAG_W 6

// Sequence numbers wrap at 64, well above the reorder depth
`define SQN_W 6
`define ROB_DEPTH 16

// Cycles from multiplier issue to writeback
`define MUL_LAT 3

`endif

/* design/execUnit.sv */
`include "coreCfg.svh"

module execUnit import renamePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    renValid,
    input  renUop_t renUop,
    input  logic    flush,
    output logic    exStall,
    output logic    wbValid,
    output wbRes_t  wbRes
);

    localparam int LAST = `MUL_LAT - 1;

    logic [`XLEN-1:0]     prfVal [`NUM_TAGS];
    logic [`NUM_TAGS-1:0] prfRdy;
    logic                 slotValid;
    renUop_t              slot;
    logic [`XLEN-1:0]     opA;
    logic [`XLEN-1:0]     opB;
    logic                 isMul;
    logic                 issue;
    wbRes_t               issueRes;
    wbRes_t               pipe [`MUL_LAT];
    logic [`MUL_LAT-1:0]  pipeV;

    assign opA = prfVal[slot.tagA];
    assign opB = slot.useImm ? slot.imm : prfVal[slot.tagB];
    assign isMul = slot.kind == opMul;

    // An ALU op may not land on the same writeback cycle as the multiplier tail
    assign issue = slotValid && prfRdy[slot.tagA] && prfRdy[slot.tagB] &&
        (isMul || !pipeV[LAST-1]);
    assign exStall = slotValid && !issue;
    assign wbValid = pipeV[LAST];
    assign wbRes = pipe[LAST];

    always_comb begin
        issueRes = '0;
        issueRes.sqN = slot.sqN;
        issueRes.tagDst = slot.tagDst;
        issueRes.rd = slot.rd;
        issueRes.pc = slot.pc;
        issueRes.target = slot.pc + slot.imm;
        case (slot.kind)
            opSub: issueRes.value = opA - opB;
            opXor: issueRes.value = opA ^ opB;
            opMul: issueRes.value = opA * opB;
            opBeq: issueRes.taken = opA == opB;
            default: issueRes.value = opA + opB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid <= 1'b0;
            pipeV <= '0;
            prfRdy <= '1;
            for (int i = 0; i < 32; i++) begin
                prfVal[i] <= '0;
            end
        end else begin
            // Tag 0 stays hard zero
            if (wbValid && wbRes.tagDst != '0) begin
                prfVal[wbRes.tagDst] <= wbRes.value;
                prfRdy[wbRes.tagDst] <= 1'b1;
            end
            if (flush) begin
                // Only younger ops are in flight, so every pending tag is dropped
                slotValid <= 1'b0;
                pipeV <= '0;
                prfRdy <= '1;
            end else begin
                pipe[0] <= issueRes;
                pipeV[0] <= issue && isMul;
                for (int i = 1; i < LAST; i++) begin
                    pipe[i] <= pipe[i-1];
                    pipeV[i] <= pipeV[i-1];
                end
                // ALU results enter at the last stage
                if (issue && !isMul) begin
                    pipe[LAST] <= issueRes;
                    pipeV[LAST] <= 1'b1;
                end else begin
                    pipe[LAST] <= pipe[LAST-1];
                    pipeV[LAST] <= pipeV[LAST-1];
                end
                if (!exStall) begin
                    slotValid <= renValid;
                    slot <= renUop;
                    if (renValid && renUop.tagDst != '0) begin
                        prfRdy[renUop.tagDst] <= 1'b0;
                    end
                end
            end
        end
    end

    aWbPending: assert property (@(posedge clk) disable iff (rst)
        wbValid && wbRes.tagDst != '0 |-> !prfRdy[wbRes.tagDst])
        else $error("writeback to tag %0d that was not pending", wbRes.tagDst);

endmodule

/* design/instrDecoder.sv */
`include "coreCfg.svh"

module instrDecoder import renamePkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             instrValid,
    input  logic [31:0]      instr,
    input  logic [`XLEN-1:0] pc,
    input  logic             stall,
    input  logic             flush,
    output logic             decValid,
    output decUop_t          decUop
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;
    decUop_t    decNext;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        decNext = '0;
        decNext.pc = pc;
        decNext.rd = instr[11:7];
        decNext.rs0 = instr[19:15];
        decNext.rs1 = instr[24:20];
        decNext.kind = opAdd;
        legal = 1'b0;
        case (opcode)
            7'b0110011: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    legal = 1'b1;
                end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    legal = 1'b1;
                    decNext.kind = opSub;
                end else if (funct3 == 3'b100 && funct7 == 7'b0000000) begin
                    legal = 1'b1;
                    decNext.kind = opXor;
                end else if (funct3 == 3'b000 && funct7 == 7'b0000001) begin
                    legal = 1'b1;
                    decNext.kind = opMul;
                end
            end
            7'b0010011: begin
                // ADDI, rs1 points at x0 so operand B never waits
                legal = funct3 == 3'b000;
                decNext.rs1 = '0;
                decNext.imm = {{20{instr[31]}}, instr[31:20]};
                decNext.useImm = 1'b1;
            end
            7'b1100011: begin
                legal = funct3 == 3'b000;
                decNext.kind = opBeq;
                decNext.rd = '0;
                decNext.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else if (flush) begin
            decValid <= 1'b0;
        end else if (!stall) begin
            decValid <= instrValid && legal;
            decUop <= decNext;
        end
    end

    aLegalOp: assert property (@(posedge clk) disable iff (rst)
        instrValid && !stall && !flush |-> legal)
        else $error("unsupported instruction %h at pc %h", instr, pc);

endmodule

/* design/regRename.sv */
`include "coreCfg.svh"

module regRename import renamePkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              decValid,
    input  decUop_t           decUop,
    input  logic              exStall,
    input  logic              comValid,
    input  comInfo_t          comInfo,
    input  logic [`SQN_W-1:0] headSqN,
    input  logic              flush,
    input  logic [`SQN_W-1:0] flushSqN,
    output logic              stallOut,
    output logic              renValid,
    output renUop_t           renUop,
    output logic              allocValid,
    output logic [`SQN_W-1:0] allocSqN
);

    typedef struct packed {
        logic [`TAG_W-1:0] comTag;
        logic [`TAG_W-1:0] specTag;
    } ratEntry_t;

    ratEntry_t            rat [32];
    logic [`NUM_TAGS-1:0] tagUsed;
    logic [`NUM_TAGS-1:0] tagCom;
    logic [`SQN_W-1:0]    counterSqN;
    logic [`SQN_W-1:0]    robCount;
    logic [`TAG_W-1:0]    freeTag;
    logic                 freeAvail;
    logic                 needTag;
    logic                 accept;
    renUop_t              renNext;

    // Lowest tag that is not in use
    always_comb begin
        freeTag = '0;
        freeAvail = 1'b0;
        for (int i = `NUM_TAGS - 1; i >= 0; i--) begin
            if (!tagUsed[i]) begin
                freeTag = `TAG_W'(i);
                freeAvail = 1'b1;
            end
        end
    end

    assign needTag = decUop.rd != '0;
    assign robCount = counterSqN - headSqN;
    assign stallOut = exStall ||
        (decValid && ((needTag && !freeAvail) || robCount >= `ROB_DEPTH));
    assign accept = decValid && !stallOut;
    assign allocValid = accept && !flush;
    assign allocSqN = counterSqN;

    always_comb begin
        renNext.sqN = counterSqN;
        renNext.kind = decUop.kind;
        renNext.rd = decUop.rd;
        renNext.tagDst = needTag ? freeTag : '0;
        renNext.tagA = rat[decUop.rs0].specTag;
        renNext.tagB = rat[decUop.rs1].specTag;
        renNext.imm = decUop.imm;
        renNext.useImm = decUop.useImm;
        renNext.pc = decUop.pc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            renValid <= 1'b0;
            counterSqN <= '0;
            for (int i = 0; i < 32; i++) begin
                rat[i].comTag <= `TAG_W'(i);
                rat[i].specTag <= `TAG_W'(i);
            end
            for (int i = 0; i < `NUM_TAGS; i++) begin
                tagUsed[i] <= i < 32;
                tagCom[i] <= i < 32;
            end
        end else begin
            if (flush) begin
                // Everything in flight is younger than the branch
                renValid <= 1'b0;
                counterSqN <= flushSqN + 1'b1;
                for (int i = 0; i < 32; i++) begin
                    rat[i].specTag <= rat[i].comTag;
                end
                for (int i = 0; i < `NUM_TAGS; i++) begin
                    if (!tagCom[i]) begin
                        tagUsed[i] <= 1'b0;
                    end
                end
            end else if (!exStall) begin
                renValid <= accept;
                if (accept) begin
                    renUop <= renNext;
                    counterSqN <= counterSqN + 1'b1;
                    if (needTag) begin
                        rat[decUop.rd].specTag <= freeTag;
                        tagUsed[freeTag] <= 1'b1;
                        tagCom[freeTag] <= 1'b0;
                    end
                end
            end

            // Committed writer replaces the older mapping, which is released
            if (comValid && comInfo.regNm != '0) begin
                tagUsed[rat[comInfo.regNm].comTag] <= 1'b0;
                tagCom[rat[comInfo.regNm].comTag] <= 1'b0;
                rat[comInfo.regNm].comTag <= comInfo.tag;
                tagUsed[comInfo.tag] <= 1'b1;
                tagCom[comInfo.tag] <= 1'b1;
            end
        end
    end

    aTagFree: assert property (@(posedge clk) disable iff (rst)
        allocValid && needTag |-> !tagCom[freeTag])
        else $error("allocation of committed tag %0d", freeTag);

endmodule

/* design/renameCore.sv */
`include "coreCfg.svh"

module renameCore import renamePkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             instrValid,
    input  logic [31:0]      instr,
    input  logic [`XLEN-1:0] pc,
    output logic             stall,
    output logic             redirect,
    output logic [`XLEN-1:0] redirectPc,
    output logic             comValid,
    output logic [4:0]       comRegNm,
    output logic [`XLEN-1:0] comValue,
    output logic [`XLEN-1:0] comPc
);

    logic              decValid;
    decUop_t           decUop;
    logic              renValid;
    renUop_t           renUop;
    logic              allocValid;
    logic [`SQN_W-1:0] allocSqN;
    logic              exStall;
    logic              wbValid;
    wbRes_t            wbRes;
    comInfo_t          comInfo;
    logic [`SQN_W-1:0] headSqN;
    logic              flush;
    logic [`SQN_W-1:0] flushSqN;

    // A taken branch flush doubles as the fetch redirect
    assign redirect = flush;

    instrDecoder instrDecoder_inst (
        .clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr), .pc(pc),
        .stall(stall), .flush(flush), .decValid(decValid), .decUop(decUop)
    );

    regRename regRename_inst (
        .clk(clk), .rst(rst), .decValid(decValid), .decUop(decUop), .exStall(exStall),
        .comValid(comValid), .comInfo(comInfo), .headSqN(headSqN), .flush(flush),
        .flushSqN(flushSqN), .stallOut(stall), .renValid(renValid), .renUop(renUop),
        .allocValid(allocValid), .allocSqN(allocSqN)
    );

    execUnit execUnit_inst (
        .clk(clk), .rst(rst), .renValid(renValid), .renUop(renUop), .flush(flush),
        .exStall(exStall), .wbValid(wbValid), .wbRes(wbRes)
    );

    commitUnit commitUnit_inst (
        .clk(clk), .rst(rst), .allocValid(allocValid), .allocSqN(allocSqN),
        .wbValid(wbValid), .wbRes(wbRes), .comValid(comValid), .comInfo(comInfo),
        .comRegNm(comRegNm), .comValue(comValue), .comPc(comPc), .headSqN(headSqN),
        .flush(flush), .flushSqN(flushSqN), .redirectPc(redirectPc)
    );

endmodule

/* design/renamePkg.sv */
`include "coreCfg.svh"

package renamePkg;

    typedef enum logic [2:0] {
        opAdd,
        opSub,
        opXor,
        opMul,
        opBeq
    } opKind_t;

    // Decoded instruction, operand B is the immediate when useImm is set
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        opKind_t          kind;
        logic [4:0]       rd;
        logic [4:0]       rs0;
        logic [4:0]       rs1;
        logic [`XLEN-1:0] imm;
        logic             useImm;
    } decUop_t;

    // Renamed micro-op, x0 destinations carry tag 0
    typedef struct packed {
        logic [`SQN_W-1:0] sqN;
        opKind_t           kind;
        logic [4:0]        rd;
        logic [`TAG_W-1:0] tagDst;
        logic [`TAG_W-1:0] tagA;
        logic [`TAG_W-1:0] tagB;
        logic [`XLEN-1:0]  imm;
        logic              useImm;
        logic [`XLEN-1:0]  pc;
    } renUop_t;

    // Result of one executed micro-op
    typedef struct packed {
        logic [`SQN_W-1:0] sqN;
        logic [`TAG_W-1:0] tagDst;
        logic [`XLEN-1:0]  value;
        logic              taken;
        logic [`XLEN-1:0]  target;
        logic [4:0]        rd;
        logic [`XLEN-1:0]  pc;
    } wbRes_t;

    typedef struct packed {
        logic [4:0]        regNm;
        logic [`TAG_W-1:0] tag;
    } comInfo_t;

endpackage

/* flist.f */
+incdir+design
design/renamePkg.sv
design/instrDecoder.sv
design/regRename.sv
design/execUnit.sv
design/commitUnit.sv
design/renameCore.sv
test/renameCoreTb.sv

/* runSim.sh */
#!/bin/sh
# Build with Verilator, run, then judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module renameCoreTb \
    -f flist.f -o renameCoreSim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/renameCoreSim > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

/* test/renameCoreTb.sv */
`include "coreCfg.svh"

module renameCoreTb;

    localparam int PROG_LEN = 512;
    localparam int NUM_CHECKS = 300;
    localparam int TIMEOUT = 40 * PROG_LEN + 100;
    localparam int START_IDLE = 10;

    // Architectural outcome of one instruction
    typedef struct packed {
        logic [4:0]       rd;
        logic [`XLEN-1:0] value;
        logic [`XLEN-1:0] nextPc;
    } refOut_t;

    logic             clk;
    logic             rst;
    logic             instrValid = 1'b0;
    logic [31:0]      instr = '0;
    logic [`XLEN-1:0] pc = '0;
    logic             stall;
    logic             redirect;
    logic [`XLEN-1:0] redirectPc;
    logic             comValid;
    logic [4:0]       comRegNm;
    logic [`XLEN-1:0] comValue;
    logic [`XLEN-1:0] comPc;

    logic [31:0]      prog [PROG_LEN];
    logic [`XLEN-1:0] archRegs [32];
    logic [31:0]      lfsrState;
    logic [`XLEN-1:0] fetchPc;
    logic [`XLEN-1:0] expPc = '0;
    logic             anyFed = 1'b0;
    int               idleLeft = 0;
    int               commitCount = 0;
    int               regWrites = 0;
    int               takenCount = 0;
    int               notTakenCount = 0;
    int               cycleCount = 0;

    renameCore renameCore_inst (
        .clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr), .pc(pc),
        .stall(stall), .redirect(redirect), .redirectPc(redirectPc),
        .comValid(comValid), .comRegNm(comRegNm), .comValue(comValue), .comPc(comPc)
    );

    // Fibonacci LFSR with taps 32, 22, 2 and 1 stepped once per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // Only x0 to x7 are used so chains and overwrites are frequent
    function automatic logic [31:0] makeInstr();
        logic [2:0]  sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [12:0] off;
        sel = 3'(takeBits(3));
        rd = 5'(takeBits(3));
        rs1 = 5'(takeBits(3));
        rs2 = 5'(takeBits(3));
        case (sel)
            3'd2: return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            3'd3: return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            3'd5: return {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
            3'd4, 3'd6: begin
                imm = 12'(takeBits(12));
                return {imm, rs1, 3'b000, rd, 7'b0010011};
            end
            3'd7: begin
                // Half of the branches compare a register with itself and are taken
                if (takeBits(1) == 32'd1) begin
                    rs2 = rs1;
                end
                off = 13'(((takeBits(2) % 3) + 2) * 4);
                return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
            end
            default: return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
        endcase
    endfunction

    function automatic refOut_t refExec(input logic [31:0] ins, input logic [`XLEN-1:0] curPc);
        refOut_t          res;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] immI;
        logic [`XLEN-1:0] immB;
        a = archRegs[ins[19:15]];
        b = archRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        res.rd = ins[11:7];
        res.value = '0;
        res.nextPc = curPc + 4;
        case (ins[6:0])
            7'b0110011: begin
                case ({ins[31:25], ins[14:12]})
                    {7'b0100000, 3'b000}: res.value = a - b;
                    {7'b0000000, 3'b100}: res.value = a ^ b;
                    {7'b0000001, 3'b000}: res.value = a * b;
                    default: res.value = a + b;
                endcase
            end
            7'b0010011: res.value = a + immI;
            default: begin
                res.rd = '0;
                if (a == b) begin
                    res.nextPc = curPc + immB;
                end
            end
        endcase
        return res;
    endfunction

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        lfsrState = 32'h0b37b1c1;
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = makeInstr();
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

    // Fetch holds on stall, follows redirects and inserts random idle gaps
    always @(posedge clk) begin
        if (rst) begin
            instrValid <= 1'b0;
            fetchPc = '0;
            idleLeft = START_IDLE;
        end else begin
            if (redirect) begin
                fetchPc = redirectPc;
            end else if (instrValid && !stall) begin
                fetchPc = fetchPc + 4;
            end
            if (redirect || !(instrValid && stall)) begin
                if (idleLeft == 0 && takeBits(3) == 32'd0) begin
                    idleLeft = 1 + takeBits(2);
                end
                if (idleLeft > 0 || fetchPc >= PROG_LEN * 4) begin
                    instrValid <= 1'b0;
                    if (idleLeft > 0) begin
                        idleLeft--;
                    end
                end else begin
                    instrValid <= 1'b1;
                    instr <= prog[fetchPc >> 2];
                    pc <= fetchPc;
                    anyFed <= 1'b1;
                end
            end
        end
    end

    // Commit checker against the architectural model
    always @(posedge clk) begin
        refOut_t want;
        logic    isBranch;
        if (rst) begin
            expPc = '0;
            for (int i = 0; i < 32; i++) begin
                archRegs[i] = '0;
            end
        end else begin
            if (!anyFed) begin
                assert (!comValid && !redirect && !stall)
                    else stopRun("Core committed, redirected or stalled before any instruction");
            end
            assert (comValid || !redirect) else stopRun("Redirect raised without a commit");
            if (comValid) begin
                assert (expPc < PROG_LEN * 4)
                    else stopRun("Commit arrived after the program ran past its end");
                want = refExec(prog[expPc >> 2], expPc);
                isBranch = prog[expPc >> 2][6:0] == 7'b1100011;
                assert (comPc == expPc) else stopRun($sformatf(
                    "Fail at time %0t: commit pc %h, expected %h", $time, comPc, expPc));
                assert (comRegNm == want.rd) else stopRun($sformatf(
                    "Fail at time %0t: pc %h wrote x%0d, expected x%0d",
                    $time, comPc, comRegNm, want.rd));
                if (want.rd != '0) begin
                    assert (comValue == want.value) else stopRun($sformatf(
                        "Fail at time %0t: pc %h value %h, expected %h",
                        $time, comPc, comValue, want.value));
                    archRegs[want.rd] = want.value;
                    regWrites++;
                end
                if (want.nextPc != expPc + 4) begin
                    assert (redirect && redirectPc == want.nextPc) else stopRun($sformatf(
                        "Fail at time %0t: taken branch at pc %h missed redirect to %h",
                        $time, comPc, want.nextPc));
                    takenCount++;
                end else begin
                    assert (!redirect) else stopRun($sformatf(
                        "Fail at time %0t: unexpected redirect at pc %h", $time, comPc));
                    if (isBranch) begin
                        notTakenCount++;
                    end
                end
                expPc = want.nextPc;
                commitCount++;
                if (commitCount == NUM_CHECKS) begin
                    if (regWrites > `NUM_TAGS && takenCount > 0 && notTakenCount > 0) begin
                        $display("TESTBENCH PASSED");
                        $finish;
                    end else begin
                        stopRun("Program did not reuse tags or cover both branch outcomes");
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT) begin
            stopRun($sformatf("Run timed out after %0d cycles with %0d of %0d commits seen",
                cycleCount, commitCount, NUM_CHECKS));
        end
    end

endmodule
